//--- apb_checker_defines.svh
////////////////////
// Width, timeout and rule count settings for the APB4 protocol checker
// Included by the packages and by every module that sizes logic from them
////////////////////

`ifndef APB_CHECKER_DEFINES_SVH
`define APB_CHECKER_DEFINES_SVH

// Bus field widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// One strobe per byte lane
`define STRB_WIDTH 4

// Width of each saturating rule counter
`define COUNT_WIDTH 8

// Cycles a selected transfer may stall before the watchdog fires
`define WATCHDOG_TIMEOUT 16

// Number of protocol rules, one counter each
`define RULE_COUNT 13

`endif

//--- apb_pkg.sv
////////////////////
// Bus side types shared by the checker modules and interfaces
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

package apb_pkg;

  // APB4 field types
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`STRB_WIDTH-1:0] strb_t;
  typedef logic [2:0]             prot_t;

  // Transfer phase as seen by the tracker
  // IDLE   next selected cycle is a setup cycle
  // SETUP  last cycle was setup, this one must be access
  // ACCESS last cycle was a wait state, still in access
  typedef enum logic [1:0]
  {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } phase_e;

endpackage : apb_pkg

`default_nettype wire

//--- checker_pkg.sv
////////////////////
// Rule numbering, severities and counter types for the checker
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

package checker_pkg;

  // Rule numbers, also the counter index
  typedef enum logic [3:0]
  {
    RULE_PSEL_DROP           = 4'd0,
    RULE_PENABLE_SETUP       = 4'd1,
    RULE_PENABLE_ACCESS      = 4'd2,
    RULE_PADDR_UNSTABLE      = 4'd3,
    RULE_PADDR_STRB_MISALIGN = 4'd4,
    RULE_PADDR_UNALIGNED     = 4'd5,
    RULE_PWRITE_UNSTABLE     = 4'd6,
    RULE_PSTRB_IRREGULAR     = 4'd7,
    RULE_PSTRB_UNSTABLE      = 4'd8,
    RULE_PSTRB_ON_READ       = 4'd9,
    RULE_PPROT_UNSTABLE      = 4'd10,
    RULE_PWDATA_UNSTABLE     = 4'd11,
    RULE_WATCHDOG            = 4'd12
  } rule_e;

  typedef enum logic
  {
    SEV_WARNING = 1'b0,
    SEV_ERROR   = 1'b1
  } severity_e;

  // Severity per rule, indexed by rule_e
  // Irregular strobe shape is the only warning
  localparam severity_e RULE_SEVERITY [`RULE_COUNT] = '{
    SEV_ERROR,   // PSEL_DROP
    SEV_ERROR,   // PENABLE_SETUP
    SEV_ERROR,   // PENABLE_ACCESS
    SEV_ERROR,   // PADDR_UNSTABLE
    SEV_ERROR,   // PADDR_STRB_MISALIGN
    SEV_ERROR,   // PADDR_UNALIGNED
    SEV_ERROR,   // PWRITE_UNSTABLE
    SEV_WARNING, // PSTRB_IRREGULAR
    SEV_ERROR,   // PSTRB_UNSTABLE
    SEV_ERROR,   // PSTRB_ON_READ
    SEV_ERROR,   // PPROT_UNSTABLE
    SEV_ERROR,   // PWDATA_UNSTABLE
    SEV_ERROR    // WATCHDOG
  };

  // One hit or sticky bit per rule
  typedef logic [`RULE_COUNT-1:0]  rule_vec_t;

  // Value of one saturating counter
  typedef logic [`COUNT_WIDTH-1:0] count_t;

endpackage : checker_pkg

`default_nettype wire

//--- apb_if.sv
////////////////////
// Internal bundles of the checker: the live bus sample and its history
////////////////////

`default_nettype none

// Current APB cycle as observed on the pins
interface apb_sample_if;
  import apb_pkg::*;

  logic  psel;
  logic  penable;
  addr_t paddr;
  logic  pwrite;
  strb_t pstrb;
  prot_t pprot;
  data_t pwdata;
  logic  pready;

  // Tracker, evaluator and watchdog only observe
  modport monitor (input psel, penable, paddr, pwrite, pstrb, pprot, pwdata, pready);
endinterface : apb_sample_if

// Phase state plus last cycle of every bus field
interface apb_history_if;
  import apb_pkg::*;

  phase_e phase;
  logic   prev_psel;
  logic   prev_penable;
  logic   prev_pready;
  addr_t  prev_paddr;
  logic   prev_pwrite;
  strb_t  prev_pstrb;
  prot_t  prev_pprot;
  data_t  prev_pwdata;

  modport tracker (output phase, prev_psel, prev_penable, prev_pready, prev_paddr,
                   prev_pwrite, prev_pstrb, prev_pprot, prev_pwdata);
  modport eval    (input  phase, prev_psel, prev_penable, prev_pready, prev_paddr,
                   prev_pwrite, prev_pstrb, prev_pprot, prev_pwdata);
endinterface : apb_history_if

`default_nettype wire

//--- apb_phase_tracker.sv
////////////////////
// Follows the APB transfer phase and keeps a one-cycle copy of the bus
////////////////////

`default_nettype none

module apb_phase_tracker (
  input logic            PCLK,
  input logic            PRESETn,
  apb_sample_if.monitor  bus,
  apb_history_if.tracker hist
);
  import apb_pkg::*;

  logic   completing;
  phase_e phase_next;

  // Slave accepts the access in this cycle
  assign completing = bus.psel & bus.penable & bus.pready;

  ////////////////////
  // Phase FSM

  always_comb
  begin
    phase_next = IDLE;
    case (hist.phase)
      // Selected from idle starts a setup cycle
      IDLE:
        if (bus.psel)
          phase_next = SETUP;
      // Current cycle is an access cycle, stay there until it completes
      SETUP, ACCESS:
        if (bus.psel && !completing)
          phase_next = ACCESS;
      default:
        phase_next = IDLE;
    endcase
  end

  // Phase and control history
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      hist.phase        <= IDLE;
      hist.prev_psel    <= 1'b0;
      hist.prev_penable <= 1'b0;
      hist.prev_pready  <= 1'b0;
    end
    else
    begin
      hist.phase        <= phase_next;
      hist.prev_psel    <= bus.psel;
      hist.prev_penable <= bus.penable;
      hist.prev_pready  <= bus.pready;
    end
  end

  ////////////////////
  // Payload history

  // Only compared while in transfer, which needs prev_psel first
  always_ff @(posedge PCLK)
  begin
    hist.prev_paddr  <= bus.paddr;
    hist.prev_pwrite <= bus.pwrite;
    hist.prev_pstrb  <= bus.pstrb;
    hist.prev_pprot  <= bus.pprot;
    hist.prev_pwdata <= bus.pwdata;
  end

endmodule : apb_phase_tracker

`default_nettype wire

//--- apb_watchdog.sv
////////////////////
// Flags a selected APB transfer that stalls past the watchdog timeout
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

module apb_watchdog (
  input  logic          PCLK,
  input  logic          PRESETn,
  apb_sample_if.monitor bus,
  output logic          wd_expired
);
  localparam int WD_BITS = $clog2(`WATCHDOG_TIMEOUT + 1);

  logic [WD_BITS-1:0] wd_count;

  // Reload when deselected or on completion
  // Otherwise count down and hold at zero
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      wd_count <= WD_BITS'(`WATCHDOG_TIMEOUT);
    else if (!bus.psel || (bus.penable && bus.pready))
      wd_count <= WD_BITS'(`WATCHDOG_TIMEOUT);
    else if (wd_count != '0)
      wd_count <= wd_count - 1'b1;
  end

  // Stays high for every selected cycle once the count is spent
  assign wd_expired = (wd_count == '0) & bus.psel;

endmodule : apb_watchdog

`default_nettype wire

//--- apb_rule_eval.sv
////////////////////
// Evaluates all APB4 protocol rules each cycle into one hit bit per rule
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

module apb_rule_eval (
  apb_sample_if.monitor         bus,
  apb_history_if.eval           hist,
  input  logic                  wd_expired,
  output checker_pkg::rule_vec_t rule_hits
);
  import apb_pkg::*;
  import checker_pkg::*;

  // Address bits that select a byte lane
  localparam int LANE_BITS = $clog2(`STRB_WIDTH);

  logic                 prev_complete;
  logic                 in_transfer;
  logic                 strb_group;
  logic [LANE_BITS-1:0] strb_start;
  logic [LANE_BITS-1:0] byte_offset;

  // Lane mask of a group of 2**size lanes at group position offset
  function automatic strb_t group_mask(input int size, input int offset);
    strb_t ones;
    ones = strb_t'((1 << (1 << size)) - 1);
    return strb_t'(ones << (offset << size));
  endfunction

  ////////////////////
  // Transfer context

  // Previous cycle was a completing access
  assign prev_complete = hist.prev_psel & hist.prev_penable & hist.prev_pready;

  // A transfer is open from the previous cycle
  assign in_transfer = hist.prev_psel & ~prev_complete;

  assign byte_offset = bus.paddr[LANE_BITS-1:0];

  ////////////////////
  // Strobe shape

  // Match against every aligned byte, halfword, word group
  // strb_start is the first lane of the matching group
  always_comb
  begin
    strb_group = 1'b0;
    strb_start = '0;
    for (int size = 0; size <= LANE_BITS; size++)
    begin
      for (int offset = 0; offset < (`STRB_WIDTH >> size); offset++)
      begin
        if (bus.pstrb == group_mask(size, offset))
        begin
          strb_group = 1'b1;
          strb_start = LANE_BITS'(offset << size);
        end
      end
    end
  end

  ////////////////////
  // Rule hits

  always_comb
  begin
    rule_hits = '0;

    // PSEL must stay high until the access completes
    rule_hits[RULE_PSEL_DROP]      = ~bus.psel & in_transfer;

    // PENABLE low in setup, high through the access
    rule_hits[RULE_PENABLE_SETUP]  = bus.psel & (hist.phase == IDLE) & bus.penable;
    rule_hits[RULE_PENABLE_ACCESS] = bus.psel & (hist.phase != IDLE) & ~bus.penable;

    // Transfer attributes frozen from setup to completion
    rule_hits[RULE_PADDR_UNSTABLE]  = bus.psel & in_transfer & (bus.paddr != hist.prev_paddr);
    rule_hits[RULE_PWRITE_UNSTABLE] = bus.psel & in_transfer &
                                      (bus.pwrite != hist.prev_pwrite);
    rule_hits[RULE_PSTRB_UNSTABLE]  = bus.psel & in_transfer & (bus.pstrb != hist.prev_pstrb);
    rule_hits[RULE_PPROT_UNSTABLE]  = bus.psel & in_transfer & (bus.pprot != hist.prev_pprot);
    rule_hits[RULE_PWDATA_UNSTABLE] = bus.psel & in_transfer &
                                      (bus.pwdata != hist.prev_pwdata);

    // Write strobe group must sit at the addressed byte
    // A non-zero offset has to be the group's first lane, which also
    // keeps the offset bits below the group size clear
    rule_hits[RULE_PADDR_STRB_MISALIGN] = bus.psel & bus.pwrite & strb_group &
                                          (byte_offset != '0) &
                                          (byte_offset != strb_start);

    // Address aligned to the data width
    rule_hits[RULE_PADDR_UNALIGNED] = bus.psel & (|byte_offset);

    // Non-zero strobe outside the regular lane groups
    rule_hits[RULE_PSTRB_IRREGULAR] = bus.psel & (|bus.pstrb) & ~strb_group;

    // Reads carry no strobes
    rule_hits[RULE_PSTRB_ON_READ]   = bus.psel & ~bus.pwrite & (|bus.pstrb);

    rule_hits[RULE_WATCHDOG]        = wd_expired;
  end

endmodule : apb_rule_eval

`default_nettype wire

//--- rule_counter.sv
////////////////////
// Saturating hit counter and sticky flag for a single protocol rule
////////////////////

`default_nettype none

module rule_counter (
  input  logic                PCLK,
  input  logic                PRESETn,
  input  logic                clear,
  input  logic                hit,
  output checker_pkg::count_t count,
  output logic                sticky
);

  // Clear wins over a hit in the same cycle
  // Count holds at all ones
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      count  <= '0;
      sticky <= 1'b0;
    end
    else if (clear)
    begin
      count  <= '0;
      sticky <= 1'b0;
    end
    else if (hit)
    begin
      if (!(&count))
        count <= count + 1'b1;
      sticky <= 1'b1;
    end
  end

endmodule : rule_counter

`default_nettype wire

//--- checker_report.sv
////////////////////
// Read mux over the rule counters and error and warning summary flags
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

module checker_report (
  input  checker_pkg::count_t    counts [`RULE_COUNT],
  input  checker_pkg::rule_vec_t stickies,
  input  checker_pkg::rule_e     rule_sel,
  output checker_pkg::count_t    sel_count,
  output logic                   error_flag,
  output logic                   warning_flag
);
  import checker_pkg::*;

  // Unused rule numbers read as zero
  always_comb
  begin
    if (int'(rule_sel) < `RULE_COUNT)
      sel_count = counts[rule_sel];
    else
      sel_count = '0;
  end

  // Fold sticky bits by severity
  always_comb
  begin
    error_flag   = 1'b0;
    warning_flag = 1'b0;
    for (int i = 0; i < `RULE_COUNT; i++)
    begin
      if (RULE_SEVERITY[i] == SEV_ERROR)
        error_flag   = error_flag | stickies[i];
      else
        warning_flag = warning_flag | stickies[i];
    end
  end

endmodule : checker_report

`default_nettype wire

//--- apb_protocol_checker.sv
////////////////////
// APB4 protocol checker top, observes the bus pins and never drives them
// Read any rule counter through rule_sel, pulse clear to reset all counts
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

module apb_protocol_checker (
  input  logic                PCLK,
  input  logic                PRESETn,
  input  logic                psel,
  input  logic                penable,
  input  apb_pkg::addr_t      paddr,
  input  logic                pwrite,
  input  apb_pkg::strb_t      pstrb,
  input  apb_pkg::prot_t      pprot,
  input  apb_pkg::data_t      pwdata,
  input  logic                pready,
  input  logic                clear,
  input  checker_pkg::rule_e  rule_sel,
  output checker_pkg::count_t sel_count,
  output logic                error_flag,
  output logic                warning_flag
);
  import checker_pkg::*;

  logic      wd_expired;
  rule_vec_t rule_hits;
  rule_vec_t stickies;
  count_t    counts [`RULE_COUNT];

  apb_sample_if  bus_if ();
  apb_history_if hist_if ();

  // Gather the pins into the sample bundle
  assign bus_if.psel    = psel;
  assign bus_if.penable = penable;
  assign bus_if.paddr   = paddr;
  assign bus_if.pwrite  = pwrite;
  assign bus_if.pstrb   = pstrb;
  assign bus_if.pprot   = pprot;
  assign bus_if.pwdata  = pwdata;
  assign bus_if.pready  = pready;

  apb_phase_tracker u_tracker (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .bus     (bus_if),
    .hist    (hist_if)
  );

  apb_watchdog u_watchdog (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .bus        (bus_if),
    .wd_expired (wd_expired)
  );

  apb_rule_eval u_eval (
    .bus        (bus_if),
    .hist       (hist_if),
    .wd_expired (wd_expired),
    .rule_hits  (rule_hits)
  );

  ////////////////////
  // One counter per rule

  for (genvar i = 0; i < `RULE_COUNT; i++)
  begin : g_rule
    rule_counter u_counter (
      .PCLK    (PCLK),
      .PRESETn (PRESETn),
      .clear   (clear),
      .hit     (rule_hits[i]),
      .count   (counts[i]),
      .sticky  (stickies[i])
    );
  end

  checker_report u_report (
    .counts       (counts),
    .stickies     (stickies),
    .rule_sel     (rule_sel),
    .sel_count    (sel_count),
    .error_flag   (error_flag),
    .warning_flag (warning_flag)
  );

endmodule : apb_protocol_checker

`default_nettype wire

//--- tb_apb_protocol_checker.sv
////////////////////
// Testbench for the APB4 protocol checker with legal and faulty APB traffic
// Keeps a shadow count per rule and checks every counter and both flags each cycle
////////////////////

`default_nettype none

`include "apb_checker_defines.svh"

module tb_apb_protocol_checker;
  timeunit 1ns;
  timeprecision 100ps;

  import apb_pkg::*;
  import checker_pkg::*;

  // Run length budget
  localparam int N_XFER       = 30;
  localparam int MAX_WAIT     = 7;
  localparam int LIMIT_CYCLES = N_XFER * (MAX_WAIT + 2) + 200;
  localparam int CLK_PERIOD   = 100;
  // Stall cycles past the timeout in the watchdog test
  localparam int WD_EXTRA     = 3;

  logic   PCLK;
  logic   PRESETn;
  logic   psel;
  logic   penable;
  addr_t  paddr;
  logic   pwrite;
  strb_t  pstrb;
  prot_t  pprot;
  data_t  pwdata;
  logic   pready;
  logic   clear;
  rule_e  rule_sel;
  count_t sel_count;
  logic   error_flag;
  logic   warning_flag;

  // Payload used by the next driven cycles
  addr_t cur_addr;
  logic  cur_write;
  strb_t cur_strb;
  prot_t cur_prot;
  data_t cur_data;

  // Shadow model
  int        exp_count [`RULE_COUNT];
  rule_vec_t pending_hits;
  logic      pending_clear;
  logic      exp_error;
  logic      exp_warning;

  int          errors;
  int          sel_idx;
  logic [31:0] lfsr;

  apb_protocol_checker dut0 (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .psel         (psel),
    .penable      (penable),
    .paddr        (paddr),
    .pwrite       (pwrite),
    .pstrb        (pstrb),
    .pprot        (pprot),
    .pwdata       (pwdata),
    .pready       (pready),
    .clear        (clear),
    .rule_sel     (rule_sel),
    .sel_count    (sel_count),
    .error_flag   (error_flag),
    .warning_flag (warning_flag)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
  end

  ////////////////////
  // Helpers

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic int random_bits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  function automatic rule_vec_t hit_of(input rule_e r);
    return rule_vec_t'(1) << r;
  endfunction

  // Irregular strobe shape is the only warning rule
  function automatic logic is_warning_rule(input int r);
    return r == int'(RULE_PSTRB_IRREGULAR);
  endfunction

  task automatic refresh_flags;
    exp_error   = 1'b0;
    exp_warning = 1'b0;
    for (int r = 0; r < `RULE_COUNT; r++)
    begin
      if (exp_count[r] != 0)
      begin
        if (is_warning_rule(r))
          exp_warning = 1'b1;
        else
          exp_error = 1'b1;
      end
    end
  endtask

  // Apply what the DUT sampled at this edge
  // Clear beats hits
  task automatic settle_expected;
    for (int r = 0; r < `RULE_COUNT; r++)
    begin
      if (pending_clear)
        exp_count[r] = 0;
      else if (pending_hits[r] && exp_count[r] < 255)
        exp_count[r] = exp_count[r] + 1;
    end
    pending_clear = 1'b0;
    pending_hits  = '0;
    refresh_flags();
  endtask

  // One bus cycle with the rules it breaks
  task automatic bus_cycle(input logic sel, input logic en, input logic rdy,
                           input rule_vec_t hits);
    @(posedge PCLK);
    settle_expected();
    pending_hits = hits;
    psel    <= sel;
    penable <= en;
    pready  <= rdy;
    paddr   <= cur_addr;
    pwrite  <= cur_write;
    pstrb   <= cur_strb;
    pprot   <= cur_prot;
    pwdata  <= cur_data;
    clear   <= 1'b0;
  endtask

  task automatic idle_cycle;
    bus_cycle(1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic pulse_clear;
    @(posedge PCLK);
    settle_expected();
    psel          <= 1'b0;
    penable       <= 1'b0;
    pready        <= 1'b0;
    clear         <= 1'b1;
    pending_clear = 1'b1;
  endtask

  // Full transfer whose selected cycles all break the same rules
  task automatic transfer(input addr_t addr, input logic wr, input strb_t strb,
                          input data_t data, input int waits, input rule_vec_t hits);
    cur_addr  = addr;
    cur_write = wr;
    cur_strb  = strb;
    cur_data  = data;
    cur_prot  = 3'b010;
    bus_cycle(1'b1, 1'b0, 1'b0, hits);
    repeat (waits) bus_cycle(1'b1, 1'b1, 1'b0, hits);
    bus_cycle(1'b1, 1'b1, 1'b1, hits);
    idle_cycle();
  endtask

  // Change one field in the second wait state of a write
  task automatic change_field(input rule_e r);
    cur_addr  = 32'h0000_0200;
    cur_write = (r != RULE_PWRITE_UNSTABLE);
    cur_strb  = (r == RULE_PWRITE_UNSTABLE) ? 4'b0000 : 4'b1111;
    cur_prot  = 3'b000;
    cur_data  = 32'h1234_5678;
    bus_cycle(1'b1, 1'b0, 1'b0, '0);
    bus_cycle(1'b1, 1'b1, 1'b0, '0);
    case (r)
      RULE_PADDR_UNSTABLE:  cur_addr  = 32'h0000_0204;
      RULE_PWRITE_UNSTABLE: cur_write = 1'b1;
      RULE_PSTRB_UNSTABLE:  cur_strb  = 4'b0001;
      RULE_PPROT_UNSTABLE:  cur_prot  = 3'b101;
      default:              cur_data  = 32'hcafe_f00d;
    endcase
    bus_cycle(1'b1, 1'b1, 1'b0, hit_of(r));
    // Completion holds the new value
    bus_cycle(1'b1, 1'b1, 1'b1, '0);
    idle_cycle();
  endtask

  ////////////////////
  // Checking

  // Walk rule_sel over all counters, one per cycle
  always @(posedge PCLK)
  begin
    sel_idx  <= (sel_idx == `RULE_COUNT - 1) ? 0 : sel_idx + 1;
    rule_sel <= rule_e'((sel_idx == `RULE_COUNT - 1) ? 0 : sel_idx + 1);
  end

  always @(negedge PCLK)
  begin
    if (PRESETn)
    begin
      assert (sel_count == count_t'(exp_count[sel_idx]))
      else
      begin
        errors = errors + 1;
        $display("[ERROR] %0t: rule %0d count is %0d, expected %0d",
                 $time, sel_idx, sel_count, exp_count[sel_idx]);
      end
      assert (warning_flag == exp_warning)
      else
      begin
        errors = errors + 1;
        $display("[ERROR] %0t: warning_flag is %0b, expected %0b",
                 $time, warning_flag, exp_warning);
      end
    end
  end

  error_flag_check: assert property (@(negedge PCLK) disable iff (!PRESETn)
                                     error_flag == exp_error)
  else
  begin
    errors = errors + 1;
    $display("[ERROR] %0t: error_flag is %0b, expected %0b", $time, error_flag, exp_error);
  end

  // Run limit
  initial
  begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////
  // Stimulus

  initial
  begin
    int    waits;
    strb_t strb;
    PRESETn  = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    paddr    = '0;
    pwrite   = 1'b0;
    pstrb    = '0;
    pprot    = '0;
    pwdata   = '0;
    pready   = 1'b0;
    clear    = 1'b0;
    rule_sel = RULE_PSEL_DROP;
    sel_idx  = 0;
    errors   = 0;
    lfsr     = 32'hda6e_301b;
    cur_addr = '0;
    cur_write = 1'b0;
    cur_strb = '0;
    cur_prot = '0;
    cur_data = '0;
    pending_hits  = '0;
    pending_clear = 1'b0;
    for (int r = 0; r < `RULE_COUNT; r++)
      exp_count[r] = 0;
    refresh_flags();

    repeat (3) @(posedge PCLK);
    PRESETn <= 1'b1;
    idle_cycle();

    // Legal writes with byte, halfword, word lanes and legal reads
    for (int i = 0; i < 12; i++)
    begin
      waits = random_bits(3);
      case (random_bits(3))
        0:       strb = 4'b0001;
        1:       strb = 4'b0100;
        2:       strb = 4'b0011;
        3:       strb = 4'b1100;
        4:       strb = 4'b1111;
        default: strb = 4'b0000;
      endcase
      transfer({18'h0, 12'(random_bits(12)), 2'b00}, strb != 4'b0000, strb,
               data_t'(random_bits(32)), waits, '0);
    end

    // PENABLE high in setup
    cur_write = 1'b1;
    cur_strb  = 4'b1111;
    cur_addr  = 32'h0000_0100;
    bus_cycle(1'b1, 1'b1, 1'b0, hit_of(RULE_PENABLE_SETUP));
    bus_cycle(1'b1, 1'b1, 1'b1, '0);
    idle_cycle();
    // PENABLE low in access
    bus_cycle(1'b1, 1'b0, 1'b0, '0);
    bus_cycle(1'b1, 1'b0, 1'b0, hit_of(RULE_PENABLE_ACCESS));
    bus_cycle(1'b1, 1'b1, 1'b1, '0);
    idle_cycle();
    // PSEL dropped in a wait state
    bus_cycle(1'b1, 1'b0, 1'b0, '0);
    bus_cycle(1'b1, 1'b1, 1'b0, '0);
    bus_cycle(1'b0, 1'b0, 1'b0, hit_of(RULE_PSEL_DROP));
    idle_cycle();

    // Stability of each field
    change_field(RULE_PADDR_UNSTABLE);
    change_field(RULE_PWRITE_UNSTABLE);
    change_field(RULE_PSTRB_UNSTABLE);
    change_field(RULE_PPROT_UNSTABLE);
    change_field(RULE_PWDATA_UNSTABLE);

    // Read back every counter before the clear
    repeat (`RULE_COUNT) idle_cycle();

    // Start the strobe tests from clean counters
    pulse_clear();
    idle_cycle();

    // Irregular strobe, warning only
    transfer(32'h0000_0300, 1'b1, 4'b0110, 32'h0, 0, hit_of(RULE_PSTRB_IRREGULAR));
    // Strobe on a read
    transfer(32'h0000_0304, 1'b0, 4'b0001, 32'h0, 0, hit_of(RULE_PSTRB_ON_READ));
    // Halfword lanes 0 and 1 at byte offset 2
    transfer(32'h0000_0302, 1'b1, 4'b0011, 32'h0, 0,
             hit_of(RULE_PADDR_STRB_MISALIGN) | hit_of(RULE_PADDR_UNALIGNED));

    // Access stalled past the timeout, then completed
    cur_addr  = 32'h0000_0400;
    cur_write = 1'b1;
    cur_strb  = 4'b1111;
    for (int c = 1; c <= `WATCHDOG_TIMEOUT + WD_EXTRA; c++)
      bus_cycle(1'b1, c > 1, 1'b0,
                (c > `WATCHDOG_TIMEOUT) ? hit_of(RULE_WATCHDOG) : rule_vec_t'(0));
    // Completing cycle still counts once the timeout is spent
    bus_cycle(1'b1, 1'b1, 1'b1, hit_of(RULE_WATCHDOG));
    idle_cycle();

    // Sweep all counters before and after the clear
    repeat (`RULE_COUNT) idle_cycle();
    pulse_clear();
    repeat (`RULE_COUNT + 1) idle_cycle();

    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule : tb_apb_protocol_checker

`default_nettype wire

//--- files.f
+incdir+.
apb_pkg.sv
checker_pkg.sv
apb_if.sv
apb_phase_tracker.sv
apb_watchdog.sv
apb_rule_eval.sv
rule_counter.sv
checker_report.sv
apb_protocol_checker.sv
tb_apb_protocol_checker.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_apb_protocol_checker
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
